/* common/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  // address and data paths of the ring
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // thread header sits ahead of the thread body
  localparam logic [ADDR_W-1:0] THREAD_HEADER_SPACE = ADDR_W'(8);

  // active flag of a ring index, left out of ordering
  localparam int INDEX_ACTIVE_BIT = 31;

  // core FSM states seen by the bridge
  typedef enum logic [4:0] {
    ST_WAIT_FOR_START = 5'd0,
    ST_READ_CMD       = 5'd1,
    ST_READ_COND      = 5'd2,
    ST_READ_SRC1      = 5'd3,
    ST_READ_SRC0      = 5'd4,
    ST_READ_DST       = 5'd5,
    ST_READ_MEM_SIZE  = 5'd6,
    ST_WRITE_REG_IP   = 5'd7,
    ST_WRITE_DST      = 5'd8,
    ST_WRITE_SRC1     = 5'd9,
    ST_WRITE_SRC0     = 5'd10,
    ST_WRITE_COND     = 5'd11,
    ST_ALU_BEGIN      = 5'd12,
    ST_EXECUTE        = 5'd13,
    ST_FINISH_BEGIN   = 5'd14,
    ST_FINISH_END     = 5'd15
  } core_state_e;

  // inter-cpu message codes
  typedef enum logic [3:0] {
    MSG_NONE             = 4'd0,
    MSG_RESET            = 4'd1,
    MSG_START            = 4'd2,
    MSG_END              = 4'd3,
    MSG_FORK_THRD        = 4'd4,
    MSG_STOP_THRD        = 4'd5,
    MSG_FORK_DONE        = 4'd6,
    MSG_STOP_DONE        = 4'd7,
    MSG_CHAN_NO_RESULTS  = 4'd8,
    MSG_CHAN_OP_ACCEPTED = 4'd9,
    MSG_CHAN_RES_RD      = 4'd10,
    MSG_CHAN_RES_WR      = 4'd11
  } cpu_msg_e;

  // passing index against our own
  typedef enum logic [1:0] {
    REL_NONE   = 2'd0,
    REL_LOWER  = 2'd1,
    REL_HIGHER = 2'd2,
    REL_SAME   = 2'd3
  } ind_rel_e;

  typedef struct packed {
    core_state_e state;
    logic        read_q;
    logic        write_q;
    logic        rw_halt;
    logic        read_dn;
    logic        write_dn;
    logic        chan_op;
    cpu_msg_e    msg;
  } core_req_t;

  typedef struct packed {
    logic              next_cpu_q;
    logic [DATA_W-1:0] cpu_index;
    cpu_msg_e          msg;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } ring_in_t;

  typedef struct packed {
    logic     next_cpu_e;
    logic     dispatcher_q;
    cpu_msg_e msg;
    logic     read_q;
    logic     write_q;
    logic     rst_e;
    logic     bus_busy;
  } ring_out_t;

  typedef struct packed {
    logic running;
    logic capture_index;
    logic announce_reset;
  } seq_status_t;

  // state classes for bus gating
  function automatic logic is_read_state(core_state_e s);
    return s inside {ST_READ_CMD, ST_READ_COND, ST_READ_SRC1, ST_READ_SRC0,
                     ST_READ_DST, ST_READ_MEM_SIZE};
  endfunction

  function automatic logic is_write_state(core_state_e s);
    return s inside {ST_WRITE_REG_IP, ST_WRITE_DST, ST_WRITE_SRC1, ST_WRITE_SRC0,
                     ST_WRITE_COND};
  endfunction

  // channel replies that carry a result
  function automatic logic is_chan_result(cpu_msg_e m);
    return m inside {MSG_CHAN_NO_RESULTS, MSG_CHAN_RES_RD, MSG_CHAN_RES_WR};
  endfunction

  // ring replies the core is allowed to see
  function automatic logic is_ring_reply(cpu_msg_e m);
    return m inside {MSG_FORK_DONE, MSG_STOP_DONE, MSG_CHAN_NO_RESULTS,
                     MSG_CHAN_OP_ACCEPTED, MSG_CHAN_RES_RD, MSG_CHAN_RES_WR};
  endfunction

endpackage

`default_nettype wire

/* hw/reset_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module reset_sequencer (
  input  wire                          clk,
  input  wire                          ext_rst_b,
  input  wire bridge_pkg::core_state_e core_state,
  output bridge_pkg::seq_status_t      seq_status,
  output logic                         rst,
  output logic                         rst_e,
  output logic                         bus_busy
);

  // restart steps, RUN is normal operation
  typedef enum logic [2:0] {
    SEQ_S1  = 3'd0,
    SEQ_S2  = 3'd1,
    SEQ_S3  = 3'd2,
    SEQ_S4  = 3'd3,
    SEQ_S5  = 3'd4,
    SEQ_RUN = 3'd5
  } seq_state_e;

  seq_state_e state;
  seq_state_e state_nxt;
  logic       finish_end;

  // core is parked at the end of a thread
  assign finish_end = (core_state == bridge_pkg::ST_FINISH_END);

  always_comb begin
    state_nxt = state;
    case (state)
      SEQ_S1: begin
        state_nxt = SEQ_S2;
      end
      SEQ_S2: begin
        // index kept from before when coming back from a finished thread
        state_nxt = finish_end ? SEQ_S4 : SEQ_S3;
      end
      SEQ_S3: begin
        state_nxt = SEQ_S4;
      end
      SEQ_S4: begin
        state_nxt = SEQ_S5;
      end
      SEQ_S5: begin
        state_nxt = SEQ_RUN;
      end
      SEQ_RUN: begin
        // thread done, go round again
        if (finish_end) begin
          state_nxt = SEQ_S1;
        end
      end
      default: begin
        state_nxt = SEQ_S1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      state      <= SEQ_S1;
      seq_status <= '0;
      rst        <= 1'b0;
      rst_e      <= 1'b0;
      bus_busy   <= 1'b0;
    end else begin
      state <= state_nxt;
      // high for the whole S3 cycle
      seq_status.capture_index  <= (state_nxt == SEQ_S3);
      seq_status.announce_reset <= (state_nxt == SEQ_S3);
      // S5 already counts as running
      seq_status.running        <= (state_nxt == SEQ_S5) || (state_nxt == SEQ_RUN);
      // one cycle pulses out of S4, after the reset message
      rst      <= (state == SEQ_S4);
      bus_busy <= (state == SEQ_S4);
      // ring reset only on a cold restart
      rst_e    <= (state == SEQ_S4) && !finish_end;
    end
  end

endmodule

`default_nettype wire

/* hw/dispatch/ring_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module ring_arbiter (
  input  wire                          clk,
  input  wire                          ext_rst_b,
  input  wire bridge_pkg::seq_status_t seq_status,
  input  wire bridge_pkg::core_req_t   core_req,
  input  wire bridge_pkg::ring_in_t    ring_in,
  output logic                         grant,
  output logic                         next_cpu_e,
  output logic                         disp_online,
  output logic                         read_q,
  output logic                         write_q,
  output bridge_pkg::ind_rel_e         cpu_ind_rel
);

  // our own place in the ring
  logic [bridge_pkg::DATA_W-1:0] cpu_index_r;

  // order part of both indices
  logic [bridge_pkg::INDEX_ACTIVE_BIT-1:0] ring_low;
  logic [bridge_pkg::INDEX_ACTIVE_BIT-1:0] own_low;

  logic mem_state;
  logic bus_done;
  logic alu_release;
  logic pass_req;

  bridge_pkg::core_state_e st;

  assign st = core_req.state;

  // index latched once per restart
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_index_r <= '0;
    end else if (seq_status.capture_index) begin
      cpu_index_r <= ring_in.cpu_index;
    end
  end

  // token is ours when the passing index matches in full
  assign grant = ring_in.next_cpu_q && (ring_in.cpu_index == cpu_index_r);

  assign ring_low = ring_in.cpu_index[bridge_pkg::INDEX_ACTIVE_BIT-1:0];
  assign own_low  = cpu_index_r[bridge_pkg::INDEX_ACTIVE_BIT-1:0];

  // relation sampled every time the token passes by
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_ind_rel <= bridge_pkg::REL_NONE;
    end else if (ring_in.next_cpu_q) begin
      if (ring_low < own_low) begin
        cpu_ind_rel <= bridge_pkg::REL_LOWER;
      end else if (ring_low > own_low) begin
        cpu_ind_rel <= bridge_pkg::REL_HIGHER;
      end else if (ring_in.cpu_index == cpu_index_r) begin
        cpu_ind_rel <= bridge_pkg::REL_SAME;
      end
    end else if (next_cpu_e) begin
      cpu_ind_rel <= bridge_pkg::REL_NONE;
    end
  end

  // reasons to hand the token on
  assign mem_state   = bridge_pkg::is_read_state(st) || bridge_pkg::is_write_state(st);
  assign bus_done    = core_req.rw_halt || core_req.read_dn || core_req.write_dn ||
                       core_req.chan_op;
  assign alu_release = (ring_in.msg == bridge_pkg::MSG_FORK_DONE) ||
                       (ring_in.msg == bridge_pkg::MSG_STOP_DONE) ||
                       bridge_pkg::is_chan_result(ring_in.msg);

  assign pass_req =
    (grant && !seq_status.running) ||
    (grant && (st == bridge_pkg::ST_WAIT_FOR_START || st == bridge_pkg::ST_FINISH_BEGIN)) ||
    (disp_online && bus_done && (mem_state || st == bridge_pkg::ST_EXECUTE)) ||
    (disp_online && st == bridge_pkg::ST_ALU_BEGIN && alu_release);

  // single cycle strobe, never back to back
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      next_cpu_e <= 1'b0;
    end else begin
      next_cpu_e <= pass_req && !next_cpu_e;
    end
  end

  // online from grant until the token leaves
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      disp_online <= 1'b0;
    end else if (!seq_status.running || next_cpu_e ||
                 st == bridge_pkg::ST_FINISH_END) begin
      // finish end drops us together with the sequencer leaving RUN
      disp_online <= 1'b0;
    end else if (grant) begin
      disp_online <= 1'b1;
    end
  end

  // bus requests reach the ring only while we hold it
  assign read_q  = disp_online && bridge_pkg::is_read_state(st) && core_req.read_q;
  assign write_q = disp_online && bridge_pkg::is_write_state(st) && core_req.write_q;

endmodule

`default_nettype wire

/* hw/dispatch/thread_control.sv */
`timescale 1ns/100ps
`default_nettype none

module thread_control (
  input  wire                          clk,
  input  wire                          ext_rst_b,
  input  wire bridge_pkg::seq_status_t seq_status,
  input  wire bridge_pkg::core_req_t   core_req,
  input  wire bridge_pkg::ring_in_t    ring_in,
  input  wire                          grant,
  input  wire                          disp_online,
  output bridge_pkg::cpu_msg_e         msg,
  output logic                         dispatcher_q,
  output logic                         next_state,
  output logic [bridge_pkg::ADDR_W-1:0] base_addr,
  output logic [bridge_pkg::ADDR_W-1:0] base_addr_data,
  output bridge_pkg::cpu_msg_e         int_cpu_msg_out
);

  // bridge's own outgoing message, one cycle long
  bridge_pkg::cpu_msg_e msg_r;

  // running seen last cycle, marks the first run cycle
  logic run_d;

  logic start_grant;
  logic finish_grant;
  logic keep_req;
  logic chan_reply;

  bridge_pkg::core_state_e st;

  assign st = core_req.state;

  // grants only count once the restart is done
  assign start_grant  = grant && seq_status.running && (st == bridge_pkg::ST_WAIT_FOR_START);
  assign finish_grant = grant && seq_status.running && (st == bridge_pkg::ST_FINISH_BEGIN);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      run_d <= 1'b0;
    end else begin
      run_d <= seq_status.running;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      msg_r <= bridge_pkg::MSG_NONE;
    end else if (seq_status.announce_reset) begin
      msg_r <= bridge_pkg::MSG_RESET;
    end else if (start_grant) begin
      msg_r <= bridge_pkg::MSG_START;
    end else if (finish_grant) begin
      msg_r <= bridge_pkg::MSG_END;
    end else begin
      msg_r <= bridge_pkg::MSG_NONE;
    end
  end

  // core steps on after start or finish
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      next_state <= 1'b0;
    end else begin
      next_state <= start_grant || finish_grant;
    end
  end

  // thread bases, data falls back to the code area when empty
  always_ff @(posedge clk) begin
    if (start_grant) begin
      base_addr <= ring_in.addr + bridge_pkg::THREAD_HEADER_SPACE;
      if (ring_in.data == '0) begin
        base_addr_data <= ring_in.addr + bridge_pkg::THREAD_HEADER_SPACE;
      end else begin
        base_addr_data <= bridge_pkg::ADDR_W'(ring_in.data) +
                          bridge_pkg::THREAD_HEADER_SPACE;
      end
    end
  end

  // states that leave the request as it is
  assign keep_req = bridge_pkg::is_read_state(st) || bridge_pkg::is_write_state(st) ||
                    st == bridge_pkg::ST_ALU_BEGIN || st == bridge_pkg::ST_FINISH_BEGIN ||
                    st == bridge_pkg::ST_FINISH_END;

  assign chan_reply = disp_online && (st == bridge_pkg::ST_ALU_BEGIN) &&
                      bridge_pkg::is_chan_result(ring_in.msg);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      dispatcher_q <= 1'b0;
    end else if (!seq_status.running) begin
      dispatcher_q <= 1'b0;
    end else if (!run_d) begin
      // S5, ask the dispatcher for work
      dispatcher_q <= 1'b1;
    end else if (finish_grant) begin
      dispatcher_q <= 1'b1;
    end else if (!grant) begin
      if (chan_reply) begin
        dispatcher_q <= 1'b1;
      end else if (!keep_req) begin
        dispatcher_q <= 1'b0;
      end
    end
  end

  // core message wins over our own
  assign msg = (core_req.msg != bridge_pkg::MSG_NONE) ? core_req.msg : msg_r;

  // only replies addressed to a core go back in
  assign int_cpu_msg_out = bridge_pkg::is_ring_reply(ring_in.msg) ? ring_in.msg
                                                                  : bridge_pkg::MSG_NONE;

endmodule

`default_nettype wire

/* hw/bridge_to_outside.sv */
`timescale 1ns/100ps
`default_nettype none

module bridge_to_outside (
  input  wire                               clk,
  input  wire                               ext_rst_b,
  input  wire bridge_pkg::core_req_t        core_req,
  input  wire bridge_pkg::ring_in_t         ring_in,
  output wire bridge_pkg::ring_out_t        ring_out,
  output wire                               rst,
  output wire                               next_state,
  output wire                               disp_online,
  output wire bridge_pkg::ind_rel_e         cpu_ind_rel,
  output wire [bridge_pkg::ADDR_W-1:0]      base_addr,
  output wire [bridge_pkg::ADDR_W-1:0]      base_addr_data,
  output wire bridge_pkg::cpu_msg_e         int_cpu_msg_out
);

  // restart sequence status shared by both ring blocks
  wire bridge_pkg::seq_status_t seq_status;

  // token matched this cycle
  wire grant;

  // pieces of the outgoing ring bundle
  wire                  next_cpu_e;
  wire                  dispatcher_q;
  wire                  read_q;
  wire                  write_q;
  wire                  rst_e;
  wire                  bus_busy;
  wire bridge_pkg::cpu_msg_e msg;

  reset_sequencer u_reset_sequencer (
    .clk        (clk),
    .ext_rst_b  (ext_rst_b),
    .core_state (core_req.state),
    .seq_status (seq_status),
    .rst        (rst),
    .rst_e      (rst_e),
    .bus_busy   (bus_busy)
  );

  ring_arbiter u_ring_arbiter (
    .clk         (clk),
    .ext_rst_b   (ext_rst_b),
    .seq_status  (seq_status),
    .core_req    (core_req),
    .ring_in     (ring_in),
    .grant       (grant),
    .next_cpu_e  (next_cpu_e),
    .disp_online (disp_online),
    .read_q      (read_q),
    .write_q     (write_q),
    .cpu_ind_rel (cpu_ind_rel)
  );

  thread_control u_thread_control (
    .clk             (clk),
    .ext_rst_b       (ext_rst_b),
    .seq_status      (seq_status),
    .core_req        (core_req),
    .ring_in         (ring_in),
    .grant           (grant),
    .disp_online     (disp_online),
    .msg             (msg),
    .dispatcher_q    (dispatcher_q),
    .next_state      (next_state),
    .base_addr       (base_addr),
    .base_addr_data  (base_addr_data),
    .int_cpu_msg_out (int_cpu_msg_out)
  );

  // ring side bundle
  assign ring_out = '{next_cpu_e: next_cpu_e, dispatcher_q: dispatcher_q, msg: msg,
                      read_q: read_q, write_q: write_q, rst_e: rst_e, bus_busy: bus_busy};

endmodule

`default_nettype wire

/* verification/bridge_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module bridge_asserts (
  input wire clk,
  input wire ext_rst_b,
  input wire next_cpu_e,
  input wire rst,
  input wire dispatcher_q,
  input wire disp_online,
  input wire running
);

  // token strobe never back to back, ring dropped right after it
  a_next_cpu_single: assert property (@(posedge clk) disable iff (ext_rst_b)
    next_cpu_e |=> !next_cpu_e && !disp_online)
    else $error("next_cpu_e repeated or still online after token pass");

  // core reset is a one cycle pulse, dispatcher request follows it
  a_rst_single: assert property (@(posedge clk) disable iff (ext_rst_b)
    rst |=> !rst && dispatcher_q)
    else $error("rst longer than one cycle or dispatcher_q not raised after it");

  // no ring ownership during a restart
  a_offline_in_restart: assert property (@(posedge clk) disable iff (ext_rst_b)
    !running |-> !disp_online)
    else $error("disp_online high while restart runs");

endmodule

bind bridge_to_outside bridge_asserts u_bridge_asserts (
  .clk          (clk),
  .ext_rst_b    (ext_rst_b),
  .next_cpu_e   (ring_out.next_cpu_e),
  .rst          (rst),
  .dispatcher_q (ring_out.dispatcher_q),
  .disp_online  (disp_online),
  .running      (seq_status.running)
);

`default_nettype wire

/* verification/tb_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_bridge;

  localparam int N_TESTS = 21;
  localparam int N_COLS = 8;
  localparam int CYCLE_LIMIT = N_TESTS * 40 + 100;
  // thread header offset added to both bases
  localparam logic [31:0] HEADER = 32'd8;

  logic clk;
  logic ext_rst_b;
  bridge_pkg::core_req_t core_req;
  bridge_pkg::ring_in_t ring_in;
  bridge_pkg::ring_out_t ring_out;
  wire rst;
  wire next_state;
  wire disp_online;
  bridge_pkg::ind_rel_e cpu_ind_rel;
  wire [31:0] base_addr;
  wire [31:0] base_addr_data;
  bridge_pkg::cpu_msg_e int_cpu_msg_out;

  // pattern words, one row of columns per test
  logic [31:0] pat [0:N_TESTS*N_COLS-1];
  logic [31:0] kind;
  logic [31:0] st_w;
  logic [31:0] own;
  logic [31:0] ring_idx;
  logic [31:0] rmsg;
  logic [31:0] addr;
  logic [31:0] data;
  logic [31:0] expv;

  integer t;
  integer n_pass;
  integer n_fail;
  integer cycles = 0;
  logic test_bad;
  // what the last restart looked like
  integer n_msg;
  integer n_rst;
  integer n_rste;
  integer n_busy;
  integer t_msg;
  integer t_rst;
  integer t_busy;
  integer t_disp;

  bridge_to_outside u_bridge_to_outside (
    .clk             (clk),
    .ext_rst_b       (ext_rst_b),
    .core_req        (core_req),
    .ring_in         (ring_in),
    .ring_out        (ring_out),
    .rst             (rst),
    .next_state      (next_state),
    .disp_online     (disp_online),
    .cpu_ind_rel     (cpu_ind_rel),
    .base_addr       (base_addr),
    .base_addr_data  (base_addr_data),
    .int_cpu_msg_out (int_cpu_msg_out)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // run limit from the number of tests
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped, cycle limit %0d reached", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  task report_fail(input string what);
    $display("FAIL %0t: %s", $time, what);
    test_bad = 1'b1;
  endtask

  // external reset for three cycles, own index on the ring bus
  task apply_reset(input logic [4:0] st, input logic [31:0] idx);
    @(posedge clk);
    ext_rst_b <= 1'b1;
    core_req <= '0;
    core_req.state <= bridge_pkg::core_state_e'(st);
    ring_in <= '0;
    ring_in.cpu_index <= idx;
    repeat (3) @(posedge clk);
    ext_rst_b <= 1'b0;
  endtask

  // follow one restart until dispatcher_q comes up again
  task watch_restart;
    integer i;
    logic low_seen;
    n_msg = 0;
    n_rst = 0;
    n_rste = 0;
    n_busy = 0;
    t_msg = -1;
    t_rst = -1;
    t_busy = -1;
    t_disp = -1;
    low_seen = 1'b0;
    for (i = 0; i < 24 && t_disp < 0; i++) begin
      @(posedge clk);
      // core leaves finish end once it has been reset
      if (n_rst > 0) begin
        core_req.state <= bridge_pkg::ST_WAIT_FOR_START;
      end
      @(negedge clk);
      if (!ring_out.dispatcher_q) begin
        low_seen = 1'b1;
      end
      if (ring_out.msg == bridge_pkg::MSG_RESET) begin
        n_msg = n_msg + 1;
        t_msg = i;
      end
      if (rst) begin
        n_rst = n_rst + 1;
        t_rst = i;
      end
      if (ring_out.rst_e) begin
        n_rste = n_rste + 1;
      end
      if (ring_out.bus_busy) begin
        n_busy = n_busy + 1;
        t_busy = i;
      end
      if (low_seen && ring_out.dispatcher_q) begin
        t_disp = i;
      end
    end
    if (t_disp < 0) begin
      $display("restart sequence never raised dispatcher_q at %0t", $time);
      test_bad = 1'b1;
    end
  endtask

  // cold restart, then park the core in the test state
  task prepare;
    apply_reset(5'd0, own);
    watch_restart();
    @(posedge clk);
    core_req.state <= bridge_pkg::core_state_e'(st_w[4:0]);
  endtask

  task pass_token;
    @(posedge clk);
    ring_in.next_cpu_q <= 1'b1;
    ring_in.cpu_index <= ring_idx;
    @(posedge clk);
    ring_in.next_cpu_q <= 1'b0;
    @(negedge clk);
  endtask

  task run_restart;
    apply_reset(st_w[4:0], own);
    watch_restart();
    if (n_msg != expv) report_fail("wrong number of reset message cycles");
    if (n_rst != 1) report_fail("rst not a single cycle");
    if (n_rste != expv) report_fail("wrong number of rst_e cycles");
    if (n_busy != 1 || t_busy != t_rst) report_fail("bus_busy not a single cycle with rst");
    if (t_disp != t_rst + 1) report_fail("dispatcher_q not one cycle after rst");
    if (expv != 0 && t_rst != t_msg + 1) report_fail("rst not right after reset message");
  endtask

  task run_relation;
    prepare();
    pass_token();
    if (cpu_ind_rel !== expv[1:0]) report_fail("wrong index relation");
  endtask

  task run_start;
    prepare();
    @(posedge clk);
    ring_in.addr <= addr;
    ring_in.data <= data;
    pass_token();
    if (ring_out.msg !== bridge_pkg::MSG_START) report_fail("start message missing");
    if (base_addr !== addr + HEADER) report_fail("wrong base_addr");
    if (base_addr_data !== expv) report_fail("wrong base_addr_data");
    if (!next_state) report_fail("next_state not pulsed");
    if (!ring_out.next_cpu_e) report_fail("token not passed on");
    @(negedge clk);
    if (next_state || ring_out.next_cpu_e) report_fail("strobe longer than one cycle");
  endtask

  task run_gating;
    prepare();
    @(posedge clk);
    core_req.read_q <= 1'b1;
    core_req.write_q <= 1'b1;
    // fill address has no effect on gating
    ring_in.addr <= $urandom();
    @(negedge clk);
    if (ring_out.read_q || ring_out.write_q) report_fail("bus request before grant");
    pass_token();
    if (!disp_online) report_fail("not online after grant");
    if (ring_out.read_q !== expv[1]) report_fail("wrong ext_read_q");
    if (ring_out.write_q !== expv[0]) report_fail("wrong ext_write_q");
    @(posedge clk);
    core_req.read_q <= 1'b0;
    core_req.write_q <= 1'b0;
  endtask

  task run_routing;
    prepare();
    @(posedge clk);
    ring_in.msg <= bridge_pkg::cpu_msg_e'(rmsg[3:0]);
    core_req.msg <= bridge_pkg::cpu_msg_e'(data[3:0]);
    @(negedge clk);
    if (int_cpu_msg_out !== expv[7:4]) report_fail("wrong message to core");
    if (ring_out.msg !== expv[3:0]) report_fail("wrong message to ring");
    @(posedge clk);
    ring_in.msg <= bridge_pkg::MSG_NONE;
    core_req.msg <= bridge_pkg::MSG_NONE;
  endtask

  task run_finish;
    prepare();
    pass_token();
    if (ring_out.msg !== expv[3:0]) report_fail("end message missing");
    if (!ring_out.dispatcher_q) report_fail("dispatcher_q not set at finish");
    if (!ring_out.next_cpu_e) report_fail("token not passed at finish");
    if (!next_state) report_fail("next_state not pulsed at finish");
    @(posedge clk);
    core_req.state <= bridge_pkg::ST_FINISH_END;
    // warm restart skips the index step
    watch_restart();
    if (n_msg != 0) report_fail("reset message after finish");
    if (n_rst != 1) report_fail("rst not a single cycle after finish");
    if (n_rste != 0) report_fail("rst_e after finish");
    if (n_busy != 1 || t_busy != t_rst) report_fail("bus_busy not with rst after finish");
    if (t_disp != t_rst + 1) report_fail("dispatcher_q not one cycle after rst");
  endtask

  initial begin
    ext_rst_b = 1'b1;
    core_req = '0;
    ring_in = '0;
    n_pass = 0;
    n_fail = 0;
    void'($urandom(41));
    $readmemh("verification/bridge_patterns.txt", pat);
    for (t = 0; t < N_TESTS; t++) begin
      kind = pat[t*N_COLS];
      st_w = pat[t*N_COLS+1];
      own = pat[t*N_COLS+2];
      ring_idx = pat[t*N_COLS+3];
      rmsg = pat[t*N_COLS+4];
      addr = pat[t*N_COLS+5];
      data = pat[t*N_COLS+6];
      expv = pat[t*N_COLS+7];
      test_bad = 1'b0;
      case (kind)
        32'd1: run_restart();
        32'd2: run_relation();
        32'd3: run_start();
        32'd4: run_gating();
        32'd5: run_routing();
        32'd6: run_finish();
        default: begin
          $display("unknown test kind %0d in pattern %0d", kind, t);
          test_bad = 1'b1;
        end
      endcase
      if (test_bad) begin
        n_fail = n_fail + 1;
      end else begin
        n_pass = n_pass + 1;
      end
      $display("test %0d kind %0d %s", t, kind, test_bad ? "failed" : "ok");
    end
    $display("tests run %0d, ok %0d, failed %0d", N_TESTS, n_pass, n_fail);
    if (n_fail == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/bridge_patterns.txt */
// kind state own_idx ring_idx ring_msg addr data expect (hex)
// kind 1 restart, 2 relation, 3 start, 4 gating, 5 routing (data is core msg), 6 finish
1 00 80000005 00000000 0 00000000 00000000 00000001
1 0F 80000005 00000000 0 00000000 00000000 00000000
1 00 00000012 00000000 0 00000000 00000000 00000001
2 0D 80000005 00000003 0 00000000 00000000 00000001
2 0D 80000005 80000009 0 00000000 00000000 00000002
2 0D 80000005 80000005 0 00000000 00000000 00000003
2 0D 80000005 00000009 0 00000000 00000000 00000002
3 00 80000005 80000005 0 00001000 00002000 00002008
3 00 80000005 80000005 0 00004000 00000000 00004008
3 00 00000007 00000007 0 FFFFFFFC 00000010 00000018
4 01 80000005 80000005 0 00000000 00000000 00000002
4 06 80000005 80000005 0 00000000 00000000 00000002
4 08 80000005 80000005 0 00000000 00000000 00000001
4 0D 80000005 80000005 0 00000000 00000000 00000000
4 0C 80000005 80000005 0 00000000 00000000 00000000
5 0D 80000005 00000000 6 00000000 00000000 00000060
5 0D 80000005 00000000 4 00000000 00000000 00000000
5 0D 80000005 00000000 A 00000000 00000005 000000A5
5 0D 80000005 00000000 9 00000000 00000000 00000090
6 0E 80000005 80000005 0 00000000 00000000 00000003
6 0E 00000022 00000022 0 00000000 00000000 00000003

/* src.f */
common/bridge_pkg.sv
hw/reset_sequencer.sv
hw/dispatch/ring_arbiter.sv
hw/dispatch/thread_control.sv
hw/bridge_to_outside.sv
verification/bridge_asserts.sv
verification/tb_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_bridge -f src.f -o vsim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
